//--- hw/rx_pkg.sv
//////////////////////////////
// widths, symbol and decode
// structs, framer states
//////////////////////////////

package rx_pkg;

    typedef logic [9:0]  symbol_t;    // bit 9 is code bit a, first on the line
    typedef logic [7:0]  byte_t;      // HGFEDCBA
    typedef logic [23:0] word_t;      // first byte in 23:16
    typedef logic [7:0]  err_cnt_t;   // saturating counters

    // framed line symbol
    typedef struct packed {
        logic    valid;   // one-cycle strobe
        symbol_t code;
    } rx_symbol_t;

    // decoder result for one symbol
    typedef struct packed {
        logic  valid;
        logic  k;         // control character
        byte_t data;
        logic  code_err;
    } dec_result_t;

    typedef enum logic {
        HUNT,
        LOCKED
    } framer_state_t;

    // K28.5 in both disparities, abcdei fghj
    localparam symbol_t COMMA_NEG = 10'b0011111010;
    localparam symbol_t COMMA_POS = 10'b1100000101;

endpackage

//--- hw/symbol_framer.sv
//////////////////////////////
// comma search and 10-bit
// symbol framing
//////////////////////////////
`timescale 1ns/10ps

module symbol_framer import rx_pkg::*; (
    input  logic       WCLK,
    input  logic       RESET_WCLK,
    input  logic       rx_bit,
    input  logic       rx_bit_valid,
    input  logic       invert_rx_data,
    output rx_symbol_t sym,
    output logic       rec_sync_ready
);

    framer_state_t state;
    symbol_t       shreg;
    symbol_t       shreg_next;
    symbol_t       sym_code;
    logic          sym_valid;
    logic [3:0]    bit_cnt;     // bits of the current symbol, 0..9
    logic          comma_hit;
    logic          emit;

    // newest bit enters at bit 0, so bit 9 holds the oldest
    assign shreg_next = {shreg[8:0], rx_bit ^ invert_rx_data};

    assign comma_hit = (shreg_next == COMMA_NEG) || (shreg_next == COMMA_POS);

    always_comb begin
        if (state == HUNT)
            emit = rx_bit_valid && comma_hit;
        else
            emit = rx_bit_valid && (bit_cnt == 4'd9);
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            state     <= HUNT;
            shreg     <= '0;
            bit_cnt   <= '0;
            sym_valid <= 1'b0;
        end else begin
            sym_valid <= emit;
            if (rx_bit_valid) begin
                shreg <= shreg_next;
                if (emit)
                    bit_cnt <= '0;              // symbol boundary
                else if (state == LOCKED)
                    bit_cnt <= bit_cnt + 1'b1;
            end
            if (state == HUNT && emit)
                state <= LOCKED;                // lock holds until reset
        end
    end

    // symbol payload
    always_ff @(posedge WCLK) begin
        if (emit)
            sym_code <= shreg_next;
    end

    assign sym = '{valid: sym_valid, code: sym_code};
    assign rec_sync_ready = (state == LOCKED);

endmodule

//--- hw/code_decoder.sv
//////////////////////////////
// 8b/10b table decoder
//////////////////////////////
`timescale 1ns/10ps

module code_decoder import rx_pkg::*; (
    input  rx_symbol_t  sym,
    output dec_result_t dec
);

    // 5b/6b, index EDCBA, RD- column as abcdei
    localparam logic [5:0] ENC6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001,
        6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100,
        6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010,
        6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110,
        6'b001110, 6'b101110, 6'b011110, 6'b101011
    };

    // 3b/4b, index HGF, RD- column as fghj, primary D.x.7
    localparam logic [3:0] ENC4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100,
        4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    logic [5:0] six;
    logic [3:0] four;
    logic       hit6, hit4;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       k28, kx7, a7, a7_ok, p7;

    assign six  = sym.code[9:4];
    assign four = sym.code[3:0];
    assign k28  = (six == 6'b001111) || (six == 6'b110000);
    assign a7   = (four == 4'b0111) || (four == 4'b1000);
    assign p7   = (four == 4'b1110) || (four == 4'b0001);

    // alternate form is the complement, except for the balanced codes
    always_comb begin
        hit6  = 1'b0;
        edcba = 5'd28;          // K28 has no data entry
        for (int i = 0; i < 32; i++) begin
            if (six == ENC6[i] ||
                (six == ~ENC6[i] && ($countones(ENC6[i]) != 3 || i == 7))) begin
                hit6  = 1'b1;
                edcba = 5'(i);
            end
        end
    end

    always_comb begin
        hit4 = a7;
        hgf  = 3'd7;
        for (int j = 0; j < 8; j++) begin
            if (four == ENC4[j] ||
                (four == ~ENC4[j] && ($countones(ENC4[j]) != 2 || j == 3))) begin
                hit4 = 1'b1;
                hgf  = 3'(j);
            end
        end
        // after 110000 the K28 balanced codes come in swapped order
        if (six == 6'b110000 && $countones(four) == 2 && four != 4'b1100 && four != 4'b0011)
            hgf = ~hgf;
    end

    always_comb begin
        case (six)
            6'b111010, 6'b110110, 6'b101110, 6'b011110: kx7 = (four == 4'b1000);
            6'b000101, 6'b001001, 6'b010001, 6'b100001: kx7 = (four == 4'b0111);
            default: kx7 = 1'b0;
        endcase
        // where the alternate x.7 is legal
        case (six)
            6'b110100, 6'b101100, 6'b011100, 6'b001111: a7_ok = (four == 4'b1000);
            6'b100011, 6'b010011, 6'b001011, 6'b110000: a7_ok = (four == 4'b0111);
            default: a7_ok = kx7;
        endcase
    end

    assign dec = '{
        valid:    sym.valid,
        k:        k28 || kx7,
        data:     {hgf, edcba},
        code_err: (!hit6 && !k28) || !hit4 || (a7 && !a7_ok) || (k28 && p7)
    };

endmodule

//--- hw/disparity_checker.sv
//////////////////////////////
// running disparity check
//////////////////////////////
`timescale 1ns/10ps

module disparity_checker import rx_pkg::*; (
    input  logic       WCLK,
    input  logic       RESET_WCLK,
    input  rx_symbol_t sym,
    output logic       disp_err
);

    logic rd_pos;               // running disparity, low is negative
    logic rd_mid;               // disparity between the sub-blocks
    logic rd_next;
    logic err6, err4;
    int   ones6, ones4;

    always_comb begin
        ones6 = $countones(sym.code[9:4]);
        ones4 = $countones(sym.code[3:0]);

        // 6b sub-block against the entry disparity
        err6 = (ones6 > 3 && rd_pos) || (ones6 < 3 && !rd_pos) ||
               (sym.code[9:4] == 6'b111000 && rd_pos) ||
               (sym.code[9:4] == 6'b000111 && !rd_pos);
        if (ones6 > 3)
            rd_mid = 1'b1;
        else if (ones6 < 3)
            rd_mid = 1'b0;
        else
            rd_mid = rd_pos;    // balanced keeps it

        err4 = (ones4 > 2 && rd_mid) || (ones4 < 2 && !rd_mid) ||
               (sym.code[3:0] == 4'b1100 && rd_mid) ||
               (sym.code[3:0] == 4'b0011 && !rd_mid);
        if (ones4 > 2)
            rd_next = 1'b1;
        else if (ones4 < 2)
            rd_next = 1'b0;
        else
            rd_next = rd_mid;
    end

    assign disp_err = err6 || err4;

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK)
            rd_pos <= 1'b0;
        else if (sym.valid)
            rd_pos <= rd_next;  // invalid symbols too
    end

endmodule

//--- hw/record_assembler.sv
//////////////////////////////
// byte to word packer and
// decoder error counter
//////////////////////////////
`timescale 1ns/10ps

module record_assembler import rx_pkg::*; (
    input  logic        WCLK,
    input  logic        RESET_WCLK,
    input  logic        enable_rx,
    input  dec_result_t dec,
    input  logic        disp_err,
    output word_t       wr_word,
    output logic        wr_en,
    output err_cnt_t    decoder_err_cnt
);

    logic [1:0] slot;           // next byte position, 0..2
    byte_t      byte0, byte1;
    logic       act;
    logic       err;
    logic       take;

    assign act  = dec.valid && enable_rx;
    assign err  = dec.code_err || disp_err;
    assign take = act && !err && !dec.k;    // a data byte to store

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            slot            <= '0;
            wr_en           <= 1'b0;
            decoder_err_cnt <= '0;
        end else begin
            wr_en <= 1'b0;
            if (act) begin
                if (err) begin
                    // partial record is thrown away
                    slot <= '0;
                    if (decoder_err_cnt != '1)
                        decoder_err_cnt <= decoder_err_cnt + 1'b1;
                end else if (dec.k) begin
                    slot <= '0;             // control char restarts the record
                end else if (slot == 2'd2) begin
                    slot  <= '0;
                    wr_en <= 1'b1;          // third byte completes the word
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // byte slots and outgoing word
    always_ff @(posedge WCLK) begin
        if (take) begin
            case (slot)
                2'd0:    byte0 <= dec.data;
                2'd1:    byte1 <= dec.data;
                default: wr_word <= {byte0, byte1, dec.data};
            endcase
        end
    end

endmodule

//--- hw/word_fifo.sv
//////////////////////////////
// word FIFO with overflow
// flag and lost-word count
//////////////////////////////
`timescale 1ns/10ps

module word_fifo import rx_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        WCLK,
    input  logic        RESET_WCLK,
    input  word_t       wr_word,
    input  logic        wr_en,
    input  logic        read,
    output word_t       data,
    output logic        empty,
    output logic [15:0] fifo_size,
    output logic        rx_fifo_full,
    output err_cnt_t    lost_data_cnt
);

    localparam int AW = $clog2(FIFO_DEPTH);

    word_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_wr, do_rd;

    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;      // no back-pressure, extra words drop
    assign do_rd = read && !empty;

    assign data      = mem[rd_ptr];     // head word falls through
    assign fifo_size = 16'(count);

    always_ff @(posedge WCLK) begin
        if (do_wr)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            rx_fifo_full  <= 1'b0;
            lost_data_cnt <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en)
                rx_fifo_full <= full;   // cleared by the next write that fits
            if (wr_en && full && lost_data_cnt != '1)
                lost_data_cnt <= lost_data_cnt + 1'b1;
        end
    end

endmodule

//--- hw/rx_record_top.sv
//////////////////////////////
// 8b/10b record receiver top
//////////////////////////////
`timescale 1ns/10ps

module rx_record_top import rx_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        WCLK,
    input  logic        RESET_WCLK,
    input  logic        rx_bit,
    input  logic        rx_bit_valid,
    input  logic        invert_rx_data,
    input  logic        enable_rx,
    input  logic        read,
    output word_t       data,
    output logic        empty,
    output logic        rx_fifo_full,
    output logic        rec_sync_ready,
    output err_cnt_t    decoder_err_cnt,
    output err_cnt_t    lost_data_cnt,
    output logic [15:0] fifo_size
);

    rx_symbol_t  sym;
    dec_result_t dec;
    logic        disp_err;
    word_t       wr_word;
    logic        wr_en;

    symbol_framer framer_i (
        .WCLK           (WCLK),
        .RESET_WCLK     (RESET_WCLK),
        .rx_bit         (rx_bit),
        .rx_bit_valid   (rx_bit_valid),
        .invert_rx_data (invert_rx_data),
        .sym            (sym),
        .rec_sync_ready (rec_sync_ready)
    );

    // decoder and disparity checker both look at the same symbol
    code_decoder decoder_i (
        .sym (sym),
        .dec (dec)
    );

    disparity_checker disp_i (
        .WCLK       (WCLK),
        .RESET_WCLK (RESET_WCLK),
        .sym        (sym),
        .disp_err   (disp_err)
    );

    record_assembler assembler_i (
        .WCLK            (WCLK),
        .RESET_WCLK      (RESET_WCLK),
        .enable_rx       (enable_rx),
        .dec             (dec),
        .disp_err        (disp_err),
        .wr_word         (wr_word),
        .wr_en           (wr_en),
        .decoder_err_cnt (decoder_err_cnt)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .WCLK          (WCLK),
        .RESET_WCLK    (RESET_WCLK),
        .wr_word       (wr_word),
        .wr_en         (wr_en),
        .read          (read),
        .data          (data),
        .empty         (empty),
        .fifo_size     (fifo_size),
        .rx_fifo_full  (rx_fifo_full),
        .lost_data_cnt (lost_data_cnt)
    );

endmodule

//--- dv/rx_record_checker.sv
//////////////////////////////
// expected words, counters
// and output compares
//////////////////////////////
`timescale 1ns/10ps

module rx_record_checker import rx_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        WCLK,
    input  logic        RESET_WCLK,
    input  logic        enable_rx,
    input  logic        read,
    input  word_t       data,
    input  logic        empty,
    input  logic        rx_fifo_full,
    input  logic        rec_sync_ready,
    input  err_cnt_t    decoder_err_cnt,
    input  err_cnt_t    lost_data_cnt,
    input  logic [15:0] fifo_size,
    input  logic        note_valid,     // last bit of a symbol is on the line
    input  logic        note_k,
    input  logic        note_err,
    input  byte_t       note_byte,
    input  logic        end_check,
    input  int          test_id,
    output int          check_count,
    output int          error_count,
    output int          exp_level
);

    word_t    exp_q [$];
    byte_t    part [2];
    int       slot;
    int       test_errors;
    logic     synced;
    logic     exp_full;
    err_cnt_t exp_err, exp_lost;

    function automatic string test_name(input int id);
        case (id)
            1: return "sync";
            2: return "packing";
            3: return "restart";
            4: return "enable";
            5: return "overflow";
            6: return "drain after overflow";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            test_errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // FIFO model that drops and counts words while full
    task automatic push_word(input word_t w);
        if (exp_q.size() == FIFO_DEPTH) begin
            exp_full = 1'b1;
            if (exp_lost != 8'hff)
                exp_lost = exp_lost + 8'd1;
        end else begin
            exp_q.push_back(w);
            exp_full = 1'b0;
        end
    endtask

    task automatic take_symbol();
        if (note_err) begin
            slot = 0;
            if (exp_err != 8'hff)
                exp_err = exp_err + 8'd1;
        end else if (note_k) begin
            slot = 0;
        end else if (slot == 2) begin
            push_word({part[0], part[1], note_byte});
            slot = 0;
        end else begin
            part[slot] = note_byte;
            slot++;
        end
    endtask

    always @(posedge WCLK) begin
        if (RESET_WCLK) begin
            exp_q.delete();
            slot        = 0;
            synced      = 1'b0;
            exp_full    = 1'b0;
            exp_err     = '0;
            exp_lost    = '0;
            test_errors = 0;
            check_count = 0;
            error_count = 0;
        end else begin
            if (!synced) begin      // quiet until the first comma
                compare("rec_sync_ready", 32'd0, 32'(rec_sync_ready));
                compare("empty", 32'd1, 32'(empty));
            end
            if (read && !empty) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    test_errors++;
                    $display("Word 0x%06h was read while no word was expected", data);
                end else begin
                    compare("data", 32'(exp_q[0]), 32'(data));
                    void'(exp_q.pop_front());
                end
            end
            if (note_valid) begin
                synced = 1'b1;
                if (enable_rx)
                    take_symbol();
            end
            if (end_check) begin
                compare("rec_sync_ready", 32'(synced), 32'(rec_sync_ready));
                compare("decoder_err_cnt", 32'(exp_err), 32'(decoder_err_cnt));
                compare("lost_data_cnt", 32'(exp_lost), 32'(lost_data_cnt));
                compare("rx_fifo_full", 32'(exp_full), 32'(rx_fifo_full));
                compare("fifo_size", 32'(exp_q.size()), 32'(fifo_size));
                if (test_errors == 0)
                    $display("test %0d %s: ok", test_id, test_name(test_id));
                else
                    $display("test %0d %s: %0d errors", test_id, test_name(test_id), test_errors);
                test_errors = 0;
            end
        end
        exp_level = exp_q.size();
    end

endmodule

//--- dv/rx_record_tb.sv
//////////////////////////////
// receiver testbench, 8b/10b
// encoder model and reader
//////////////////////////////
`timescale 1ns/10ps

module rx_record_tb import rx_pkg::*; ();

    localparam int DEPTH      = 16;
    localparam int WAIT_LIMIT = 400;

    // standard 5b/6b codes, index EDCBA, RD- column as abcdei
    localparam logic [5:0] CODE6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // 3b/4b codes, index HGF, RD- column as fghj
    localparam logic [3:0] CODE4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    logic        WCLK, RESET_WCLK;
    logic        rx_bit, rx_bit_valid, invert_rx_data, enable_rx, read;
    word_t       data;
    logic        empty, rx_fifo_full, rec_sync_ready;
    err_cnt_t    decoder_err_cnt, lost_data_cnt;
    logic [15:0] fifo_size;
    logic        note_valid, note_k, note_err, end_check;
    byte_t       note_byte;
    int          test_id, check_count, error_count, exp_level, tests_run;
    int          seed;
    logic        line_rd;       // encoder running disparity, low is negative

    rx_record_top #(.FIFO_DEPTH(DEPTH)) UUT (.*);

    rx_record_checker #(.FIFO_DEPTH(DEPTH)) rx_record_checker (.*);

    initial begin
        WCLK = 1'b0;
        forever #5 WCLK = ~WCLK;
    end

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    // ones-count rule per sub-block
    function automatic logic disparity_after(input symbol_t s, input logic rd);
        logic r;
        r = rd;
        if ($countones(s[9:4]) > 3)
            r = 1'b1;
        else if ($countones(s[9:4]) < 3)
            r = 1'b0;
        if ($countones(s[3:0]) > 2)
            r = 1'b1;
        else if ($countones(s[3:0]) < 2)
            r = 1'b0;
        return r;
    endfunction

    function automatic symbol_t encode_byte(input byte_t d, input logic rd);
        logic [5:0] s6;
        logic [3:0] s4;
        logic       mid;
        s6 = CODE6[d[4:0]];
        if (rd && ($countones(s6) != 3 || d[4:0] == 5'd7))
            s6 = ~s6;
        mid = disparity_after({s6, 4'b0011}, rd);   // balanced dummy keeps the 6b result
        s4 = CODE4[d[7:5]];
        // A7 avoids a run of five across e i f g h
        if (d[7:5] == 3'd7 &&
            ((!mid && (d[4:0] == 5'd17 || d[4:0] == 5'd18 || d[4:0] == 5'd20)) ||
             (mid && (d[4:0] == 5'd11 || d[4:0] == 5'd13 || d[4:0] == 5'd14))))
            s4 = 4'b0111;
        if (mid && ($countones(s4) != 2 || d[7:5] == 3'd3))
            s4 = ~s4;
        return {s6, s4};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge WCLK);
    endtask

    // random gap, then one strobed bit; the last bit of a symbol also carries the note
    task automatic send_bit(input logic b, input logic last);
        int gap;
        gap = int'(next_random() % 32'd3);
        repeat (gap) @(negedge WCLK);
        rx_bit       = b ^ invert_rx_data;
        rx_bit_valid = 1'b1;
        note_valid   = last;
        @(negedge WCLK);
        rx_bit_valid = 1'b0;
        note_valid   = 1'b0;
    endtask

    task automatic send_symbol(input symbol_t s, input logic k, input logic err, input byte_t b);
        note_k    = k;
        note_err  = err;
        note_byte = b;
        for (int i = 9; i >= 0; i--)
            send_bit(s[i], i == 0);             // bit a goes first
        line_rd = disparity_after(s, line_rd);
    endtask

    task automatic send_comma();
        send_symbol(line_rd ? COMMA_POS : COMMA_NEG, 1'b1, 1'b0, 8'hbc);
    endtask

    task automatic send_data(input byte_t b);
        send_symbol(encode_byte(b, line_rd), 1'b0, 1'b0, b);
    endtask

    task automatic send_error();
        send_symbol(10'b1111111111, 1'b0, 1'b1, 8'h00);
    endtask

    // three bytes and one or two fillers
    task automatic send_record();
        logic [31:0] r;
        r = next_random();
        send_data(r[7:0]);
        send_data(r[15:8]);
        send_data(r[23:16]);
        repeat (1 + int'(r[24])) send_comma();
    endtask

    task automatic wait_word();
        int n;
        n = 0;
        while (empty && n < WAIT_LIMIT) begin
            @(negedge WCLK);
            n++;
        end
        if (empty) begin
            $display("Timeout: no word reached the FIFO within %0d cycles", WAIT_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_level > 0 && n < 4 * DEPTH) begin
            wait_word();
            read = 1'b1;
            @(negedge WCLK);
            read = 1'b0;
            idle(int'(next_random() % 32'd2));
            n++;
        end
    endtask

    // the receive path takes 3 cycles after the last bit
    task automatic finish_test(input int id);
        idle(4);
        test_id   = id;
        end_check = 1'b1;
        @(negedge WCLK);
        end_check = 1'b0;
        tests_run++;
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        seed           = 32'hdf0e_ab31;
        RESET_WCLK     = 1'b1;
        rx_bit         = 1'b0;
        rx_bit_valid   = 1'b0;
        invert_rx_data = 1'b0;
        enable_rx      = 1'b1;
        read           = 1'b0;
        note_valid     = 1'b0;
        note_k         = 1'b0;
        note_err       = 1'b0;
        note_byte      = '0;
        end_check      = 1'b0;
        test_id        = 0;
        tests_run      = 0;
        line_rd        = 1'b0;
        repeat (8) @(posedge WCLK);
        @(negedge WCLK);
        RESET_WCLK = 1'b0;

        // alternating bits never hold a comma, so the offset is arbitrary
        idle(5);
        n = 1 + int'(next_random() % 32'd20);
        for (int i = 0; i < n; i++)
            send_bit(i[0], 1'b0);
        repeat (3) send_comma();
        finish_test(1);

        repeat (6) send_record();
        drain();
        invert_rx_data = 1'b1;
        idle(2);
        repeat (6) send_record();
        drain();
        finish_test(2);

        repeat (8) begin
            r = next_random();
            send_data(r[7:0]);
            if (r[8])
                send_data(r[15:8]);
            if (r[9])
                send_error();
            else
                send_comma();
            send_record();
        end
        drain();
        finish_test(3);

        invert_rx_data = 1'b0;
        enable_rx      = 1'b0;
        idle(2);
        repeat (4) send_record();
        send_data(8'h5a);
        send_error();
        idle(4);
        enable_rx = 1'b1;
        send_comma();
        repeat (2) send_record();
        drain();
        finish_test(4);

        repeat (DEPTH + 5) send_record();       // nobody reads
        finish_test(5);
        drain();
        finish_test(6);

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- build.f
hw/rx_pkg.sv
hw/symbol_framer.sv
hw/code_decoder.sv
hw/disparity_checker.sv
hw/record_assembler.sv
hw/word_fifo.sv
hw/rx_record_top.sv
dv/rx_record_checker.sv
dv/rx_record_tb.sv

//--- Makefile
# Verilator build and run of the 8b/10b record receiver testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rx_record_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless it passes"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
